// ==== project.f ====
+incdir+sim
verilog/rs_forney_pkg.sv
verilog/forney_sequencer.sv
verilog/forney_evaluator.sv
verilog/forney_result_bank.sv
verilog/rs_forney_top.sv
sim/tb_rs_forney.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Forney stage testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

TOP=tb_rs_forney
BUILD_LOG=build.log
SIM_LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module "$TOP" \
    -o "$TOP" > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$SIM_LOG"; then
    exit 0
fi

echo "pass line not found in $SIM_LOG"
exit 1

// ==== sim/forney_vectors.svh ====
`ifndef FORNEY_VECTORS_SVH
`define FORNEY_VECTORS_SVH

// columns: omega, lambda_odd, err_loc, expected err_val, expected err_loc_out, abort flag
// hex words hold slot T-1 in the top byte and slot 0 in the bottom byte
localparam int NUM_VECTORS = 5;

// Omega0 in the low byte
localparam rs_forney_pkg::sym_t [T-1:0] VEC_OMEGA [NUM_VECTORS] = '{
    32'h0000_051b,
    32'h4433_2211,
    32'h0530_0620,
    32'h0000_0402,
    32'h0102_0304
};

// Lambda1 in the low byte, Lambda3 in the high byte
localparam rs_forney_pkg::sym_t [T/2-1:0] VEC_LAMBDA_ODD [NUM_VECTORS] = '{
    16'h0005,
    16'h0000,
    16'h0302,
    16'h0002,
    16'h0101
};

localparam rs_forney_pkg::sym_t [T-1:0] VEC_ERR_LOC [NUM_VECTORS] = '{
    32'hffff_ff02,
    32'h0aff_0905,
    32'h0107_0003,
    32'hff06_0504,
    32'hffff_ffff
};

// single error, zero Lambda', four errors, restart row, all empty
localparam rs_forney_pkg::sym_t [T-1:0] VEC_EXP_VAL [NUM_VECTORS] = '{
    32'h0000_000f,
    32'h0000_0000,
    32'h1c37_1620,
    32'h001c_8141,
    32'h0000_0000
};

localparam rs_forney_pkg::sym_t [T-1:0] VEC_EXP_LOC [NUM_VECTORS] = '{
    32'hffff_ff02,
    32'h0aff_0905,
    32'h0107_0003,
    32'hff06_0504,
    32'hffff_ffff
};

// set: a run on scrambled inputs is started first and cut off after two cycles
localparam logic VEC_ABORT_FIRST [NUM_VECTORS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

`endif

// ==== sim/tb_rs_forney.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rs_forney;

    localparam int T            = 4;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 4;
    localparam int HOLD_CYCLES  = 2;

    `include "forney_vectors.svh"

    localparam int TIMEOUT_CYCLES = NUM_VECTORS * (T + 4) + 50;

    logic                            clk;
    logic                            rst_n;
    logic                            start;
    rs_forney_pkg::sym_t [T-1:0]     omega;
    rs_forney_pkg::sym_t [T/2-1:0]   lambda_odd;
    rs_forney_pkg::sym_t [T-1:0]     err_loc;
    rs_forney_pkg::sym_t [T-1:0]     err_val;
    rs_forney_pkg::sym_t [T-1:0]     err_loc_out;
    logic                            done;
    int                              cycle_count = 0;

    rs_forney_top #(
        .T (T)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .omega       (omega),
        .lambda_odd  (lambda_odd),
        .err_loc     (err_loc),
        .err_val     (err_val),
        .err_loc_out (err_loc_out),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic report_failure(input string msg);
        $display("%s (at %0t)", msg, $time);
        $display("STATUS: FAIL");
        $fatal(1, "stopping on first failure");
    endtask

    task automatic check_sym(input string name, input rs_forney_pkg::sym_t expected,
                             input rs_forney_pkg::sym_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected 0x%02h, actual 0x%02h",
                     $time, name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "symbol mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %b, actual %b",
                     $time, name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "bit mismatch");
        end
    endtask

    // scrambled means the bitwise inverse of the row
    task automatic drive_inputs(input int row, input logic scrambled);
        if (scrambled) begin
            omega      = ~VEC_OMEGA[row];
            lambda_odd = ~VEC_LAMBDA_ODD[row];
            err_loc    = ~VEC_ERR_LOC[row];
        end else begin
            omega      = VEC_OMEGA[row];
            lambda_odd = VEC_LAMBDA_ODD[row];
            err_loc    = VEC_ERR_LOC[row];
        end
    endtask

    // one-cycle start, inputs changed right after the capture edge
    task automatic pulse_start(input int row, input logic scrambled);
        @(posedge clk);
        #DRIVE_DLY;
        start = 1'b1;
        drive_inputs(row, scrambled);
        @(posedge clk);
        #DRIVE_DLY;
        start = 1'b0;
        drive_inputs(row, 1'b1);
    endtask

    // counts negedges after the capture edge until done is seen
    task automatic wait_done(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (done !== 1'b1);
    endtask

    task automatic check_results(input int row);
        for (int i = 0; i < T; i++) begin
            check_sym($sformatf("err_val[%0d]", i), VEC_EXP_VAL[row][i], err_val[i]);
            check_sym($sformatf("err_loc_out[%0d]", i), VEC_EXP_LOC[row][i], err_loc_out[i]);
        end
    endtask

    initial begin
        int latency;
        rst_n      = 1'b0;
        start      = 1'b0;
        omega      = '0;
        lambda_odd = '0;
        err_loc    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        @(negedge clk);
        check_bit("done", 1'b0, done);
        for (int i = 0; i < T; i++) begin
            check_sym($sformatf("err_val[%0d]", i), 8'h00, err_val[i]);
            check_sym($sformatf("err_loc_out[%0d]", i), 8'hff, err_loc_out[i]);
        end

        for (int row = 0; row < NUM_VECTORS; row++) begin
            if (VEC_ABORT_FIRST[row]) begin
                pulse_start(row, 1'b1);
            end
            pulse_start(row, 1'b0);
            wait_done(latency);
            if (latency != T + 1) begin
                report_failure($sformatf("row %0d: done came %0d cycles after start, not %0d",
                                         row, latency, T + 1));
            end
            check_results(row);
            // single-cycle done, then results must hold
            @(negedge clk);
            check_bit("done", 1'b0, done);
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                check_bit("done", 1'b0, done);
            end
            check_results(row);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/forney_evaluator.sv ====
`timescale 1ns/10ps
`default_nettype none

module forney_evaluator #(
    parameter int T = 4
) (
    input  wire rs_forney_pkg::sym_t                  cur_loc,
    input  wire rs_forney_pkg::sym_t [T-1:0]          omega_q,
    input  wire rs_forney_pkg::sym_t [T/2-1:0]        lambda_odd_q,
    output rs_forney_pkg::sym_t                       slot_val
);

    rs_forney_pkg::sym_t x;
    rs_forney_pkg::sym_t x_sq;
    rs_forney_pkg::sym_t omega_at_x;
    rs_forney_pkg::sym_t lambda_der;
    rs_forney_pkg::sym_t x_pow;
    logic                is_empty;

    // X = alpha^(loc+1)
    assign x        = rs_forney_pkg::gf_pow_alpha(32'(cur_loc) + 32'd1);
    assign x_sq     = rs_forney_pkg::gf_mul(x, x);
    assign is_empty = (cur_loc == rs_forney_pkg::EMPTY_LOC);

    // Omega(X), Horner from the highest coefficient down
    always_comb begin
        omega_at_x = omega_q[T-1];
        for (int i = T - 2; i >= 0; i--) begin
            omega_at_x = rs_forney_pkg::gf_mul(omega_at_x, x) ^ omega_q[i];
        end
    end

    // Lambda'(X) in char 2: only odd terms survive,
    // lambda1 + lambda3*X^2 + ...
    always_comb begin
        lambda_der = '0;
        x_pow      = rs_forney_pkg::sym_t'(1);
        for (int j = 0; j < T / 2; j++) begin
            lambda_der = lambda_der ^ rs_forney_pkg::gf_mul(lambda_odd_q[j], x_pow);
            x_pow      = rs_forney_pkg::gf_mul(x_pow, x_sq);
        end
    end

    // division by multiplying with the inverse
    always_comb begin
        if (is_empty || lambda_der == '0) begin
            slot_val = '0;
        end else begin
            slot_val = rs_forney_pkg::gf_mul(omega_at_x, rs_forney_pkg::gf_inv(lambda_der));
        end
    end

endmodule

`default_nettype wire

// ==== verilog/forney_result_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module forney_result_bank #(
    parameter int T = 4
) (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire                                       clear,
    input  wire                                       slot_wr,
    input  wire [((T > 1) ? $clog2(T) : 1)-1:0]       slot_idx,
    input  wire rs_forney_pkg::sym_t                  slot_val,
    input  wire rs_forney_pkg::sym_t                  slot_loc,
    output rs_forney_pkg::sym_t [T-1:0]               err_val,
    output rs_forney_pkg::sym_t [T-1:0]               err_loc_out
);

    // visible outputs, so same state on reset and on clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < T; i++) begin
                err_val[i]     <= '0;
                err_loc_out[i] <= rs_forney_pkg::EMPTY_LOC;
            end
        end else if (clear) begin
            for (int i = 0; i < T; i++) begin
                err_val[i]     <= '0;
                err_loc_out[i] <= rs_forney_pkg::EMPTY_LOC;
            end
        end else if (slot_wr) begin
            err_val[slot_idx]     <= slot_val;
            err_loc_out[slot_idx] <= slot_loc;
        end
    end

    // sequencer must drop the write on a restart cycle
    a_no_clear_during_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(clear && slot_wr)
    ) else $error("clear and slot_wr active in the same cycle");

endmodule

`default_nettype wire

// ==== verilog/forney_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module forney_sequencer #(
    parameter int T = 4
) (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire                                       start,
    input  wire rs_forney_pkg::sym_t [T-1:0]          omega,
    input  wire rs_forney_pkg::sym_t [T/2-1:0]        lambda_odd,
    input  wire rs_forney_pkg::sym_t [T-1:0]          err_loc,
    output rs_forney_pkg::sym_t [T-1:0]               omega_q,
    output rs_forney_pkg::sym_t [T/2-1:0]             lambda_odd_q,
    output rs_forney_pkg::sym_t                       cur_loc,
    output logic [((T > 1) ? $clog2(T) : 1)-1:0]      slot_idx,
    output logic                                      slot_wr,
    output rs_forney_pkg::sym_t                       slot_loc,
    output logic                                      clear,
    output logic                                      done
);

    localparam int IDX_W = (T > 1) ? $clog2(T) : 1;

    rs_forney_pkg::sym_t [T-1:0] loc_q;
    logic                        running;
    logic                        last_slot;

    // input snapshot, held for the whole run
    always_ff @(posedge clk) begin
        if (start) begin
            omega_q      <= omega;
            lambda_odd_q <= lambda_odd;
            loc_q        <= err_loc;
        end
    end

    assign last_slot = (slot_idx == IDX_W'(T - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            slot_idx <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                // also restarts an active run, no done for the old one
                running  <= 1'b1;
                slot_idx <= '0;
            end else if (running) begin
                if (last_slot) begin
                    running  <= 1'b0;
                    slot_idx <= '0;
                    done     <= 1'b1;
                end else begin
                    slot_idx <= slot_idx + 1'b1;
                end
            end
        end
    end

    // a restart pulse wins over the pending slot write
    assign slot_wr  = running & ~start;
    assign clear    = start;
    assign cur_loc  = loc_q[slot_idx];
    assign slot_loc = loc_q[slot_idx];

    a_done_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    ) else $error("done held longer than one cycle");

    a_idx_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        running |-> (int'(slot_idx) < T)
    ) else $error("slot_idx out of range while running");

endmodule

`default_nettype wire

// ==== verilog/rs_forney_pkg.sv ====
`default_nettype none

package rs_forney_pkg;

    // field is GF(2^8), primitive element alpha = 0x02
    parameter int SYM_BW = 8;

    typedef logic [SYM_BW-1:0] sym_t;

    // x^8 + x^4 + x^3 + x^2 + 1
    parameter logic [SYM_BW:0] GF_POLY = 9'h11d;

    parameter int unsigned GF_ORDER = 255;

    // chien search marks unused slots with this
    parameter sym_t EMPTY_LOC = 8'hff;

    // shift-and-add multiply, reduced by GF_POLY on every shift
    function automatic sym_t gf_mul(input sym_t a, input sym_t b);
        logic [SYM_BW:0] shifted;
        sym_t            prod;
        shifted = {1'b0, a};
        prod    = '0;
        for (int i = 0; i < SYM_BW; i++) begin
            if (b[i]) begin
                prod = prod ^ shifted[SYM_BW-1:0];
            end
            shifted = {shifted[SYM_BW-1:0], 1'b0};
            if (shifted[SYM_BW]) begin
                shifted = shifted ^ GF_POLY;
            end
        end
        return prod;
    endfunction

    // alpha^e with e taken mod the group order
    function automatic sym_t gf_pow_alpha(input int unsigned e);
        sym_t ex;
        sym_t base;
        sym_t result;
        ex     = sym_t'(e % GF_ORDER);
        base   = sym_t'(2);
        result = sym_t'(1);
        // square and multiply over the exponent bits
        for (int i = 0; i < SYM_BW; i++) begin
            if (ex[i]) begin
                result = gf_mul(result, base);
            end
            base = gf_mul(base, base);
        end
        return result;
    endfunction

    // a^-1 = a^254 since a^255 = 1 for any nonzero a
    function automatic sym_t gf_inv(input sym_t a);
        sym_t ex;
        sym_t base;
        sym_t result;
        ex     = sym_t'(GF_ORDER - 1);
        base   = a;
        result = sym_t'(1);
        if (a == '0) begin
            result = '0;
        end else begin
            for (int i = 0; i < SYM_BW; i++) begin
                if (ex[i]) begin
                    result = gf_mul(result, base);
                end
                base = gf_mul(base, base);
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/rs_forney_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs_forney_top #(
    parameter int T = 4
) (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire                                       start,
    input  wire rs_forney_pkg::sym_t [T-1:0]          omega,
    input  wire rs_forney_pkg::sym_t [T/2-1:0]        lambda_odd,
    input  wire rs_forney_pkg::sym_t [T-1:0]          err_loc,
    output rs_forney_pkg::sym_t [T-1:0]               err_val,
    output rs_forney_pkg::sym_t [T-1:0]               err_loc_out,
    output logic                                      done
);

    localparam int IDX_W = (T > 1) ? $clog2(T) : 1;

    rs_forney_pkg::sym_t [T-1:0]   omega_q;
    rs_forney_pkg::sym_t [T/2-1:0] lambda_odd_q;
    rs_forney_pkg::sym_t           cur_loc;
    rs_forney_pkg::sym_t           slot_val;
    rs_forney_pkg::sym_t           slot_loc;
    logic [IDX_W-1:0]              slot_idx;
    logic                          slot_wr;
    logic                          clear;

    forney_sequencer #(
        .T (T)
    ) u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .omega        (omega),
        .lambda_odd   (lambda_odd),
        .err_loc      (err_loc),
        .omega_q      (omega_q),
        .lambda_odd_q (lambda_odd_q),
        .cur_loc      (cur_loc),
        .slot_idx     (slot_idx),
        .slot_wr      (slot_wr),
        .slot_loc     (slot_loc),
        .clear        (clear),
        .done         (done)
    );

    // one slot per cycle, no pipelining
    forney_evaluator #(
        .T (T)
    ) u_eval (
        .cur_loc      (cur_loc),
        .omega_q      (omega_q),
        .lambda_odd_q (lambda_odd_q),
        .slot_val     (slot_val)
    );

    forney_result_bank #(
        .T (T)
    ) u_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (clear),
        .slot_wr      (slot_wr),
        .slot_idx     (slot_idx),
        .slot_val     (slot_val),
        .slot_loc     (slot_loc),
        .err_val      (err_val),
        .err_loc_out  (err_loc_out)
    );

endmodule

`default_nettype wire
